/* elink_pkg.sv */
package elink_pkg;

   //##########################################################################
   // widths with a meaning
   //##########################################################################
   typedef logic [31:0] mesh_addr_t;   // full mesh address
   typedef logic [31:0] mesh_data_t;   // one data word
   typedef logic [29:0] axi_addr_t;    // byte address seen on the axi port
   typedef logic [11:0] link_id_t;     // node id, top 12 address bits
   typedef logic [3:0]  ctrlmode_t;    // mesh routing control
   typedef logic [1:0]  datamode_t;    // 0 byte, 1 half-word, 2 word
   typedef logic [3:0]  reg_group_t;   // register group in addr 19..16
   typedef logic [19:0] reg_addr_t;    // local register address

   // axi burst type
   // wrap bursts get no special handling and run like fixed ones
   typedef enum logic [1:0] {
      burst_fixed = 2'b00,
      burst_incr  = 2'b01,
      burst_wrap  = 2'b10
   } burst_e;

   //##########################################################################
   // mesh transaction
   //##########################################################################
   // write flag and source address are implied by the port a packet leaves on
   typedef struct packed {
      logic       access;     // one-cycle valid
      datamode_t  datamode;   // transfer size
      ctrlmode_t  ctrlmode;
      mesh_addr_t dstaddr;
      mesh_data_t data;       // zero on read requests
   } mesh_pkt_t;

   // register block groups
   localparam reg_group_t grp_mmr   = 4'd0;
   localparam reg_group_t grp_rxmmu = 4'd1;
   localparam reg_group_t grp_txmmu = 4'd2;
   localparam reg_group_t grp_embox = 4'd3;

   localparam int addr_lsb = 2;   // byte offset bits inside one word

endpackage

/* esaxi_read.sv */
module esaxi_read import elink_pkg::*;
(
   input  logic       s_axi_aclk,
   input  logic       s_axi_aresetn,
   // read address channel
   input  axi_addr_t  s_axi_araddr,
   input  burst_e     s_axi_arburst,
   input  logic [7:0] s_axi_arlen,
   input  logic [2:0] s_axi_arsize,
   input  logic       s_axi_arvalid,
   output logic       s_axi_arready,
   // read data channel
   input  logic       s_axi_rready,
   output logic       s_axi_rvalid,
   output logic       s_axi_rlast,
   output logic [1:0] s_axi_rresp,
   output mesh_data_t s_axi_rdata,
   // config
   input  link_id_t   ecfg_coreid,
   input  ctrlmode_t  ecfg_tx_ctrlmode,
   // request out, response back from the router
   output mesh_pkt_t  rd_pkt,
   input  logic       rsp_valid,
   input  mesh_data_t rsp_data
);

   logic       read_active;   // burst in progress
   logic       ar_hs;
   logic       rd_hs;
   logic       last_rd_hs;
   logic [7:0] beats_left;    // beats after the current one
   mesh_addr_t ar_addr;       // current beat address
   mesh_addr_t next_addr;
   datamode_t  ar_size;
   datamode_t  next_size;
   burst_e     ar_burst;
   mesh_data_t rsp_fmt;       // response laid out by size

   assign ar_hs       = s_axi_arready & s_axi_arvalid;
   assign rd_hs       = s_axi_rvalid & s_axi_rready;
   assign last_rd_hs  = rd_hs & s_axi_rlast;
   assign s_axi_rresp = 2'b00;

   //##########################################################################
   // address channel
   //##########################################################################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_arready <= 1'b0;
         read_active   <= 1'b0;
      end
      else
      begin
         if (ar_hs)
            s_axi_arready <= 1'b0;
         else if (!read_active)
            s_axi_arready <= 1'b1;

         if (ar_hs)
            read_active <= 1'b1;
         else if (last_rd_hs)
            read_active <= 1'b0;   // last beat taken
      end
   end

   // address of the beat to request next
   // the request goes out the cycle after the handshake, so it uses this value
   always_comb
   begin
      next_addr = ar_addr;
      next_size = ar_size;
      if (ar_hs)
      begin
         next_addr = {ecfg_coreid[11:10], s_axi_araddr};
         next_size = s_axi_arsize[1:0];
      end
      else if (rd_hs && ar_burst == burst_incr)
      begin
         next_addr[31:addr_lsb]  = ar_addr[31:addr_lsb] + 1'b1;
         next_addr[addr_lsb-1:0] = '0;   // word aligned after first beat
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      ar_addr <= next_addr;
      ar_size <= next_size;
      if (ar_hs)
      begin
         ar_burst   <= s_axi_arburst;
         beats_left <= s_axi_arlen;
      end
      else if (rd_hs)
         beats_left <= beats_left - 1'b1;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         s_axi_rlast <= 1'b0;
      else if (ar_hs)
         s_axi_rlast <= (s_axi_arlen == 8'd0);   // single beat burst
      else if (rd_hs)
         s_axi_rlast <= (beats_left == 8'd1);
   end

   //##########################################################################
   // mesh request, one per beat
   //##########################################################################
   always_ff @(posedge s_axi_aclk)
   begin
      rd_pkt.access   <= ar_hs | (rd_hs & ~s_axi_rlast);
      rd_pkt.datamode <= next_size;
      rd_pkt.ctrlmode <= ecfg_tx_ctrlmode;
      rd_pkt.dstaddr  <= next_addr;
      rd_pkt.data     <= '0;   // nothing to carry on a request
      if (!s_axi_aresetn)
         rd_pkt.access <= 1'b0;
   end

   //##########################################################################
   // read data
   //##########################################################################
   always_comb
   begin
      case (ar_size)
         2'd0:    rsp_fmt = {4{rsp_data[7:0]}};    // byte on every lane
         2'd1:    rsp_fmt = {2{rsp_data[15:0]}};   // half-word twice
         default: rsp_fmt = rsp_data;
      endcase
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (rsp_valid)
         s_axi_rdata <= rsp_fmt;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         s_axi_rvalid <= 1'b0;
      else if (rsp_valid)
         s_axi_rvalid <= 1'b1;
      else if (s_axi_rready)
         s_axi_rvalid <= 1'b0;   // held until taken
   end

endmodule

/* esaxi_router.sv */
module esaxi_router import elink_pkg::*;
#(
   parameter link_id_t elink_id = 12'h810
)
(
   input  logic       s_axi_aclk,
   input  logic       s_axi_aresetn,
   // from the axi paths
   input  mesh_pkt_t  wr_pkt,
   input  mesh_pkt_t  rd_pkt,
   // mesh ports
   output mesh_pkt_t  emwr_pkt,
   output mesh_pkt_t  emrq_pkt,
   input  logic       emrr_access,
   input  mesh_data_t emrr_data,
   output logic       emrr_rd_en,
   // register interface
   output logic       mi_en,
   output logic       mi_we,
   output reg_addr_t  mi_addr,
   output mesh_data_t mi_din,
   output logic [3:0] mi_sel,        // mmr, rxmmu, txmmu, embox
   input  mesh_data_t mi_mmr_dout,
   input  mesh_data_t mi_rxmmu_dout,
   input  mesh_data_t mi_txmmu_dout,
   input  mesh_data_t mi_embox_dout,
   // read response to esaxi_read
   output logic       rsp_valid,
   output mesh_data_t rsp_data
);

   logic       wr_local;   // write hits this link's registers
   logic       rd_local;
   reg_addr_t  reg_addr;   // write wins the register port
   reg_group_t grp;
   logic [3:0] sel_dec;    // one-hot block select
   logic       mi_rd;      // register read on the port now
   logic [3:0] sel_q;      // selects kept for readback
   logic       rb_valid;   // register data returning
   logic       rr_valid;   // mesh data returning
   mesh_data_t rr_data;
   mesh_data_t rb_data;

   assign wr_local = wr_pkt.access & (wr_pkt.dstaddr[31:20] == elink_id);
   assign rd_local = rd_pkt.access & (rd_pkt.dstaddr[31:20] == elink_id);
   assign reg_addr = wr_local ? wr_pkt.dstaddr[19:0] : rd_pkt.dstaddr[19:0];
   assign grp      = reg_addr[19:16];
   assign mi_rd    = mi_en & ~mi_we;

   always_comb
   begin
      sel_dec = 4'b0000;
      if (wr_local || rd_local)
      begin
         case (grp)
            grp_mmr:   sel_dec = 4'b0001;
            grp_rxmmu: sel_dec = 4'b0010;
            grp_txmmu: sel_dec = 4'b0100;
            grp_embox: sel_dec = 4'b1000;
            default:   sel_dec = 4'b0000;   // unmapped group, no block
         endcase
      end
   end

   //##########################################################################
   // mesh side
   //##########################################################################
   always_ff @(posedge s_axi_aclk)
   begin
      emwr_pkt        <= wr_pkt;
      emwr_pkt.access <= wr_pkt.access & ~wr_local;
      emrq_pkt        <= rd_pkt;
      emrq_pkt.access <= rd_pkt.access & ~rd_local;
      if (!s_axi_aresetn)
      begin
         emwr_pkt.access <= 1'b0;
         emrq_pkt.access <= 1'b0;
      end
   end

   //##########################################################################
   // register side
   //##########################################################################
   always_ff @(posedge s_axi_aclk)
   begin
      mi_addr <= reg_addr;
      mi_din  <= wr_pkt.data;
      if (!s_axi_aresetn)
      begin
         mi_en  <= 1'b0;
         mi_we  <= 1'b0;
         mi_sel <= 4'b0000;
      end
      else
      begin
         mi_en  <= wr_local | rd_local;
         mi_we  <= wr_local;
         mi_sel <= sel_dec;
      end
   end

   // readback and mesh response
   // one read outstanding, so the two never return together
   assign emrr_rd_en = emrr_access & ~rb_valid;

   always_ff @(posedge s_axi_aclk)
   begin
      sel_q   <= mi_sel;
      rr_data <= emrr_data;
      if (!s_axi_aresetn)
      begin
         rb_valid <= 1'b0;
         rr_valid <= 1'b0;
      end
      else
      begin
         rb_valid <= mi_rd;
         rr_valid <= emrr_rd_en;
      end
   end

   assign rb_data = ({32{sel_q[0]}} & mi_mmr_dout)   |
                    ({32{sel_q[1]}} & mi_rxmmu_dout) |
                    ({32{sel_q[2]}} & mi_txmmu_dout) |
                    ({32{sel_q[3]}} & mi_embox_dout);

   assign rsp_valid = rb_valid | rr_valid;
   assign rsp_data  = rb_valid ? rb_data : rr_data;

endmodule

/* esaxi_top.sv */
module esaxi_top import elink_pkg::*;
#(
   parameter link_id_t elink_id = 12'h810   // address tag of the local registers
)
(
   input  logic       s_axi_aclk,
   input  logic       s_axi_aresetn,
   // axi write address
   input  axi_addr_t  s_axi_awaddr,
   input  burst_e     s_axi_awburst,
   input  logic [2:0] s_axi_awsize,
   input  logic       s_axi_awvalid,
   output logic       s_axi_awready,
   // axi write data
   input  mesh_data_t s_axi_wdata,
   input  logic [3:0] s_axi_wstrb,
   input  logic       s_axi_wlast,
   input  logic       s_axi_wvalid,
   output logic       s_axi_wready,
   // axi write response
   input  logic       s_axi_bready,
   output logic       s_axi_bvalid,
   output logic [1:0] s_axi_bresp,
   // axi read address
   input  axi_addr_t  s_axi_araddr,
   input  burst_e     s_axi_arburst,
   input  logic [7:0] s_axi_arlen,
   input  logic [2:0] s_axi_arsize,
   input  logic       s_axi_arvalid,
   output logic       s_axi_arready,
   // axi read data
   input  logic       s_axi_rready,
   output logic       s_axi_rvalid,
   output logic       s_axi_rlast,
   output logic [1:0] s_axi_rresp,
   output mesh_data_t s_axi_rdata,
   // mesh
   output mesh_pkt_t  emwr_pkt,
   input  logic       emwr_progfull,
   output mesh_pkt_t  emrq_pkt,
   input  logic       emrr_access,
   input  mesh_data_t emrr_data,
   output logic       emrr_rd_en,
   // register interface
   output logic       mi_en,
   output logic       mi_we,
   output reg_addr_t  mi_addr,
   output mesh_data_t mi_din,
   output logic [3:0] mi_sel,
   input  mesh_data_t mi_mmr_dout,
   input  mesh_data_t mi_rxmmu_dout,
   input  mesh_data_t mi_txmmu_dout,
   input  mesh_data_t mi_embox_dout,
   // config
   input  link_id_t   ecfg_coreid,
   input  ctrlmode_t  ecfg_tx_ctrlmode
);

   mesh_pkt_t  wr_pkt;      // write beat packets
   mesh_pkt_t  rd_pkt;      // read beat requests
   logic       rsp_valid;
   mesh_data_t rsp_data;

   esaxi_write u_write (
      .s_axi_aclk       (s_axi_aclk),
      .s_axi_aresetn    (s_axi_aresetn),
      .s_axi_awaddr     (s_axi_awaddr),
      .s_axi_awburst    (s_axi_awburst),
      .s_axi_awsize     (s_axi_awsize),
      .s_axi_awvalid    (s_axi_awvalid),
      .s_axi_awready    (s_axi_awready),
      .s_axi_wdata      (s_axi_wdata),
      .s_axi_wstrb      (s_axi_wstrb),
      .s_axi_wlast      (s_axi_wlast),
      .s_axi_wvalid     (s_axi_wvalid),
      .s_axi_wready     (s_axi_wready),
      .s_axi_bready     (s_axi_bready),
      .s_axi_bvalid     (s_axi_bvalid),
      .s_axi_bresp      (s_axi_bresp),
      .emwr_progfull    (emwr_progfull),
      .ecfg_coreid      (ecfg_coreid),
      .ecfg_tx_ctrlmode (ecfg_tx_ctrlmode),
      .wr_pkt           (wr_pkt)
   );

   esaxi_read u_read (
      .s_axi_aclk       (s_axi_aclk),
      .s_axi_aresetn    (s_axi_aresetn),
      .s_axi_araddr     (s_axi_araddr),
      .s_axi_arburst    (s_axi_arburst),
      .s_axi_arlen      (s_axi_arlen),
      .s_axi_arsize     (s_axi_arsize),
      .s_axi_arvalid    (s_axi_arvalid),
      .s_axi_arready    (s_axi_arready),
      .s_axi_rready     (s_axi_rready),
      .s_axi_rvalid     (s_axi_rvalid),
      .s_axi_rlast      (s_axi_rlast),
      .s_axi_rresp      (s_axi_rresp),
      .s_axi_rdata      (s_axi_rdata),
      .ecfg_coreid      (ecfg_coreid),
      .ecfg_tx_ctrlmode (ecfg_tx_ctrlmode),
      .rd_pkt           (rd_pkt),
      .rsp_valid        (rsp_valid),
      .rsp_data         (rsp_data)
   );

   // mesh or local registers, per packet
   esaxi_router #(
      .elink_id (elink_id)
   ) u_router (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .wr_pkt        (wr_pkt),
      .rd_pkt        (rd_pkt),
      .emwr_pkt      (emwr_pkt),
      .emrq_pkt      (emrq_pkt),
      .emrr_access   (emrr_access),
      .emrr_data     (emrr_data),
      .emrr_rd_en    (emrr_rd_en),
      .mi_en         (mi_en),
      .mi_we         (mi_we),
      .mi_addr       (mi_addr),
      .mi_din        (mi_din),
      .mi_sel        (mi_sel),
      .mi_mmr_dout   (mi_mmr_dout),
      .mi_rxmmu_dout (mi_rxmmu_dout),
      .mi_txmmu_dout (mi_txmmu_dout),
      .mi_embox_dout (mi_embox_dout),
      .rsp_valid     (rsp_valid),
      .rsp_data      (rsp_data)
   );

endmodule

/* esaxi_write.sv */
module esaxi_write import elink_pkg::*;
(
   input  logic       s_axi_aclk,
   input  logic       s_axi_aresetn,
   // write address channel
   input  axi_addr_t  s_axi_awaddr,
   input  burst_e     s_axi_awburst,
   input  logic [2:0] s_axi_awsize,
   input  logic       s_axi_awvalid,
   output logic       s_axi_awready,
   // write data channel
   input  mesh_data_t s_axi_wdata,
   input  logic [3:0] s_axi_wstrb,
   input  logic       s_axi_wlast,
   input  logic       s_axi_wvalid,
   output logic       s_axi_wready,
   // write response channel
   input  logic       s_axi_bready,
   output logic       s_axi_bvalid,
   output logic [1:0] s_axi_bresp,
   // mesh side
   input  logic       emwr_progfull,
   input  link_id_t   ecfg_coreid,
   input  ctrlmode_t  ecfg_tx_ctrlmode,
   output mesh_pkt_t  wr_pkt
);

   logic       write_active;   // address taken, beats still to come
   logic       aw_hs;
   logic       wr_beat;
   logic       last_wr_beat;
   mesh_addr_t aw_addr;        // address of the next beat
   datamode_t  aw_size;
   burst_e     aw_burst;
   logic [1:0] strb_idx;       // lowest enabled byte lane
   mesh_pkt_t  pkt_s1;         // first packet stage

   assign aw_hs        = s_axi_awready & s_axi_awvalid;
   assign wr_beat      = s_axi_wready & s_axi_wvalid;
   assign last_wr_beat = wr_beat & s_axi_wlast;
   assign s_axi_bresp  = 2'b00;   // always okay

   //##########################################################################
   // address channel
   //##########################################################################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_awready <= 1'b0;
         write_active  <= 1'b0;
      end
      else
      begin
         if (aw_hs)
            s_axi_awready <= 1'b0;
         else if (!write_active && !s_axi_bvalid)
            s_axi_awready <= 1'b1;   // idle, previous response consumed

         if (aw_hs)
            write_active <= 1'b1;
         else if (last_wr_beat)
            write_active <= 1'b0;
      end
   end

   // top two core id bits complete the 30 bit axi address
   always_ff @(posedge s_axi_aclk)
   begin
      if (aw_hs)
      begin
         aw_addr  <= {ecfg_coreid[11:10], s_axi_awaddr};
         aw_size  <= s_axi_awsize[1:0];
         aw_burst <= s_axi_awburst;
      end
      else if (wr_beat && aw_burst == burst_incr)
      begin
         aw_addr[31:addr_lsb]  <= aw_addr[31:addr_lsb] + 1'b1;   // next word
         aw_addr[addr_lsb-1:0] <= '0;
      end
   end

   //##########################################################################
   // data channel and response
   //##########################################################################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         s_axi_wready <= 1'b0;
      else if (last_wr_beat)
         s_axi_wready <= 1'b0;
      else
         s_axi_wready <= write_active & ~emwr_progfull;   // one cycle behind full
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         s_axi_bvalid <= 1'b0;
      else if (last_wr_beat)
         s_axi_bvalid <= 1'b1;
      else if (s_axi_bready)
         s_axi_bvalid <= 1'b0;
   end

   // lowest set strobe picks the shift
   always_comb
   begin
      casez (s_axi_wstrb)
         4'b???1: strb_idx = 2'd0;   // aligned
         4'b??10: strb_idx = 2'd1;
         4'b?100: strb_idx = 2'd2;
         default: strb_idx = 2'd3;
      endcase
   end

   //##########################################################################
   // packet pipeline
   //##########################################################################
   always_ff @(posedge s_axi_aclk)
   begin
      pkt_s1.access   <= wr_beat;
      pkt_s1.datamode <= aw_size;
      pkt_s1.ctrlmode <= ecfg_tx_ctrlmode;
      pkt_s1.dstaddr  <= {aw_addr[31:addr_lsb], strb_idx};   // lane index as lsbs
      pkt_s1.data     <= s_axi_wdata >> {strb_idx, 3'b000};  // zeros fill from top
      if (!s_axi_aresetn)
         pkt_s1.access <= 1'b0;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      wr_pkt <= pkt_s1;
      if (!s_axi_aresetn)
         wr_pkt.access <= 1'b0;
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the esaxi testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_esaxi -o sim_esaxi
if [ $? -ne 0 ]; then
   echo "compile step failed"
   exit 1
fi

./obj_dir/sim_esaxi > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi
if ! grep -q "Regression passed" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0

/* sources.f */
elink_pkg.sv
esaxi_write.sv
esaxi_read.sv
esaxi_router.sv
esaxi_top.sv
+incdir+.
tb_esaxi.sv

/* tb_esaxi_util.svh */
`ifndef TB_ESAXI_UTIL_SVH
`define TB_ESAXI_UTIL_SVH

   //##########################################################################
   // random bits and error handling
   //##########################################################################
   // fibonacci lfsr with taps 32 22 2 1
   // stepped once for every bit handed out
   function automatic logic [31:0] rand_bits(input int nbits);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < nbits; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   task automatic fail_now(input string msg);
      $display("%s at time %0t", msg, $time);
      $display("Regression failed");
      $fatal(1);
   endtask

   task automatic check_val(input string what, input logic [127:0] got,
                            input logic [127:0] exp);
      if (got !== exp)
      begin
         $display("ERR %0t %s: got %h expected %h", $time, what, got, exp);
         $display("Regression failed");
         $fatal(1);
      end
   endtask

   //##########################################################################
   // axi drivers that queue expected values as beats go out
   //##########################################################################
   task automatic write_burst(input axi_addr_t awaddr, input burst_e burst,
                              input logic [1:0] size, input int len,
                              input logic local_hit);
      mesh_addr_t a;
      mesh_data_t d;
      logic [3:0] s;
      mesh_pkt_t  p;
      wr_exp_t    we;
      mi_exp_t    me;
      exp_b++;   // one response owed per burst
      s_axi_awaddr  = awaddr;
      s_axi_awburst = burst;
      s_axi_awsize  = {1'b0, size};
      s_axi_awvalid = 1'b1;
      while (!s_axi_awready)
         @(negedge s_axi_aclk);
      @(negedge s_axi_aclk);
      s_axi_awvalid = 1'b0;
      a = {ecfg_coreid[11:10], awaddr};
      for (int i = 0; i < len; i++)
      begin
         d = rand_bits(32);
         s = 4'(rand_bits(4));
         if (s == 4'b0000)
            s = 4'b1000;   // top lane only
         s_axi_wdata  = d;
         s_axi_wstrb  = s;
         s_axi_wlast  = (i == len - 1);
         s_axi_wvalid = 1'b1;
         while (!s_axi_wready)
            @(negedge s_axi_aclk);
         p = expect_write_pkt(a, d, s, size);
         if (local_hit)
         begin
            me.addr = p.dstaddr[19:0];
            me.din  = p.data;
            me.sel  = 4'b0001 << awaddr[17:16];
            me.cyc  = cyc + 3;   // three cycles after the beat
            exp_mi.push_back(me);
         end
         else
         begin
            we.pkt = p;
            we.cyc = cyc + 3;
            exp_wr.push_back(we);
         end
         if (burst == burst_incr)
            a = {a[31:2] + 30'd1, 2'b00};
         @(negedge s_axi_aclk);
      end
      s_axi_wvalid = 1'b0;
      s_axi_wlast  = 1'b0;
      while (!s_axi_bvalid)
         @(negedge s_axi_aclk);
      @(negedge s_axi_aclk);
   endtask

   task automatic read_burst(input axi_addr_t araddr, input burst_e burst,
                             input logic [1:0] size, input int len,
                             input logic local_hit);
      mesh_addr_t a;
      mesh_data_t w;
      mesh_pkt_t  q;
      rd_exp_t    r;
      a = {ecfg_coreid[11:10], araddr};
      for (int i = 0; i < len; i++)
      begin
         if (local_hit)
            w = block_word(araddr[17:16]);
         else
         begin
            q          = '0;
            q.access   = 1'b1;
            q.datamode = size;
            q.ctrlmode = ecfg_tx_ctrlmode;
            q.dstaddr  = a;
            exp_rq.push_back(q);
            w = resp_word(a);
         end
         r.last = (i == len - 1);
         r.data = fmt_by_size(w, size);
         exp_rd.push_back(r);
         if (burst == burst_incr)
            a = {a[31:2] + 30'd1, 2'b00};
      end
      s_axi_araddr  = araddr;
      s_axi_arburst = burst;
      s_axi_arlen   = 8'(len - 1);
      s_axi_arsize  = {1'b0, size};
      s_axi_arvalid = 1'b1;
      while (!s_axi_arready)
         @(negedge s_axi_aclk);
      @(negedge s_axi_aclk);
      s_axi_arvalid = 1'b0;
      while (!(s_axi_rvalid && s_axi_rlast))
         @(negedge s_axi_aclk);
      @(negedge s_axi_aclk);
   endtask

`endif

/* tb_esaxi.sv */
module tb_esaxi import elink_pkg::*;
();

   localparam int n_wr       = 40;
   localparam int n_rd       = 40;
   localparam int max_len    = 8;
   localparam int wd_cycles  = (n_wr + n_rd + 1) * (max_len + 2) * 16 + 400;
   localparam link_id_t link = 12'h810;

   typedef struct packed {
      mesh_pkt_t   pkt;
      logic [31:0] cyc;   // expected cycle of emwr access
   } wr_exp_t;

   typedef struct packed {
      reg_addr_t   addr;
      mesh_data_t  din;
      logic [3:0]  sel;
      logic [31:0] cyc;
   } mi_exp_t;

   typedef struct packed {
      logic       last;
      mesh_data_t data;
   } rd_exp_t;

   logic s_axi_aclk, s_axi_aresetn;
   axi_addr_t s_axi_awaddr, s_axi_araddr;
   burst_e s_axi_awburst, s_axi_arburst;
   logic [2:0] s_axi_awsize, s_axi_arsize;
   logic s_axi_awvalid, s_axi_awready, s_axi_wlast, s_axi_wvalid, s_axi_wready;
   mesh_data_t s_axi_wdata, s_axi_rdata, emrr_data, mi_din;
   logic [3:0] s_axi_wstrb, mi_sel;
   logic s_axi_bready, s_axi_bvalid, s_axi_arvalid, s_axi_arready;
   logic [1:0] s_axi_bresp, s_axi_rresp;
   logic [7:0] s_axi_arlen;
   logic s_axi_rready, s_axi_rvalid, s_axi_rlast;
   mesh_pkt_t emwr_pkt, emrq_pkt;
   logic emwr_progfull, emrr_access, emrr_rd_en, mi_en, mi_we;
   reg_addr_t mi_addr;
   link_id_t ecfg_coreid;
   ctrlmode_t ecfg_tx_ctrlmode;

   logic [31:0] lfsr = 32'h721f_169a;
   logic [31:0] cyc = 0;          // rising edges since start
   logic [31:0] pf_start = 0;     // cycle the full flag went up
   int          exp_b = 0;        // write responses still owed
   wr_exp_t     exp_wr[$];
   mi_exp_t     exp_mi[$];
   mesh_pkt_t   exp_rq[$];
   rd_exp_t     exp_rd[$];

   // one dout word per register block
   localparam mesh_data_t dout_mmr   = 32'h1357_9bdf;
   localparam mesh_data_t dout_rx    = 32'h2468_ace0;
   localparam mesh_data_t dout_tx    = 32'h0f1e_2d3c;
   localparam mesh_data_t dout_embox = 32'hc3a5_5a3c;

   always #2 s_axi_aclk = ~s_axi_aclk;
   always @(posedge s_axi_aclk) cyc <= cyc + 1;

   esaxi_top #(.elink_id(link)) i_esaxi_top (.*,
      .mi_mmr_dout(dout_mmr), .mi_rxmmu_dout(dout_rx),
      .mi_txmmu_dout(dout_tx), .mi_embox_dout(dout_embox));

   //##########################################################################
   // reference model
   //##########################################################################
   function automatic mesh_pkt_t expect_write_pkt(input mesh_addr_t a, input mesh_data_t d,
                                                  input logic [3:0] s, input logic [1:0] size);
      mesh_pkt_t p;
      int        lane;
      lane = 3;
      for (int i = 3; i >= 0; i--)
         if (s[i])
            lane = i;   // lowest set strobe wins
      p.access   = 1'b1;
      p.datamode = size;
      p.ctrlmode = ecfg_tx_ctrlmode;
      p.dstaddr  = {a[31:2], 2'(lane)};
      p.data     = d >> (8 * lane);
      return p;
   endfunction

   function automatic mesh_data_t fmt_by_size(input mesh_data_t w, input logic [1:0] size);
      if (size == 2'd0)
         return {w[7:0], w[7:0], w[7:0], w[7:0]};
      else if (size == 2'd1)
         return {w[15:0], w[15:0]};
      return w;
   endfunction

   function automatic mesh_data_t block_word(input logic [1:0] grp);
      case (grp)
         2'd0:    return dout_mmr;
         2'd1:    return dout_rx;
         2'd2:    return dout_tx;
         default: return dout_embox;
      endcase
   endfunction

   // mesh memory content as seen by the responder
   function automatic mesh_data_t resp_word(input mesh_addr_t a);
      return {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
   endfunction

   `include "tb_esaxi_util.svh"

   //##########################################################################
   // compare dut outputs with queued entries
   //##########################################################################
   always @(negedge s_axi_aclk)
   begin : compare
      wr_exp_t we;
      mi_exp_t me;
      rd_exp_t re;
      if (s_axi_aresetn)
      begin
         if (emwr_pkt.access)
         begin
            if (emwr_progfull && cyc > pf_start + 3)
               fail_now("mesh write packet while the full flag was held");
            if (exp_wr.size() == 0)
               fail_now("mesh write packet that no write beat asked for");
            we = exp_wr.pop_front();
            check_val("emwr_pkt", emwr_pkt, we.pkt);
            check_val("emwr cycle", cyc, we.cyc);   // beat plus 3
         end
         if (mi_en && mi_we)
         begin
            if (exp_mi.size() == 0)
               fail_now("register write that no write beat asked for");
            me = exp_mi.pop_front();
            check_val("mi write", {mi_addr, mi_din, mi_sel, cyc}, me);
         end
         if (emrq_pkt.access)
         begin
            if (exp_rq.size() == 0)
               fail_now("mesh read request that no read beat asked for");
            check_val("emrq_pkt", emrq_pkt, exp_rq.pop_front());
         end
         if (s_axi_rvalid && s_axi_rready)
         begin
            if (exp_rd.size() == 0)
               fail_now("read data beat that no read asked for");
            re = exp_rd.pop_front();
            check_val("rdata rlast", {s_axi_rlast, s_axi_rdata}, re);
            check_val("rresp", s_axi_rresp, 2'b00);
         end
         if (s_axi_bvalid && s_axi_bready)
         begin
            if (exp_b == 0)
               fail_now("write response with no burst finished");
            exp_b--;
            check_val("bresp", s_axi_bresp, 2'b00);
         end
      end
   end

   // mesh responder serving one request at a time
   initial
   begin : responder
      mesh_addr_t ra;
      int         dly;
      forever
      begin
         @(negedge s_axi_aclk);
         if (s_axi_aresetn && emrq_pkt.access)
         begin
            ra  = emrq_pkt.dstaddr;
            dly = 1 + int'(rand_bits(8) % 5);
            repeat (dly) @(negedge s_axi_aclk);
            emrr_access = 1'b1;
            emrr_data   = resp_word(ra);
            #1 check_val("emrr_rd_en", emrr_rd_en, 1'b1);
            @(negedge s_axi_aclk);
            emrr_access = 1'b0;
         end
      end
   end

   initial
   begin : watchdog
      #(wd_cycles * 4);
      $display("timeout: the tests did not finish in %0d cycles", wd_cycles);
      $display("Regression failed");
      $fatal(1);
   end

   //##########################################################################
   // stimulus
   //##########################################################################
   initial
   begin : stimulus
      logic        loc;
      logic [1:0]  grp;
      s_axi_aclk       = 1'b0;
      s_axi_aresetn    = 1'b0;
      s_axi_awaddr     = '0;
      s_axi_awburst    = burst_incr;
      s_axi_awsize     = 3'd2;
      s_axi_awvalid    = 1'b0;
      s_axi_wdata      = '0;
      s_axi_wstrb      = 4'hf;
      s_axi_wlast      = 1'b0;
      s_axi_wvalid     = 1'b0;
      s_axi_bready     = 1'b1;
      s_axi_araddr     = '0;
      s_axi_arburst    = burst_incr;
      s_axi_arlen      = '0;
      s_axi_arsize     = 3'd2;
      s_axi_arvalid    = 1'b0;
      s_axi_rready     = 1'b1;
      emwr_progfull    = 1'b0;
      emrr_access      = 1'b0;
      emrr_data        = '0;
      ecfg_coreid      = link;
      ecfg_tx_ctrlmode = 4'h6;
      repeat (5) @(negedge s_axi_aclk);
      s_axi_aresetn = 1'b1;
      repeat (3) @(negedge s_axi_aclk);

      for (int i = 0; i < n_wr; i++)
      begin
         grp = 2'(rand_bits(2));
         if (i % 4 == 3)   // single beat register write
            write_burst({10'h010, 2'b00, grp, 16'(rand_bits(16))}, burst_incr,
                        2'(rand_bits(2) % 3), 1, 1'b1);
         else
            write_burst({1'b1, 29'(rand_bits(29))}, burst_e'(rand_bits(2) % 3),
                        2'(rand_bits(2) % 3), 1 + int'(rand_bits(3)), 1'b0);
      end

      // full flag held in the middle of a long burst
      fork
         write_burst({1'b1, 29'(rand_bits(29))}, burst_incr, 2'd2, max_len, 1'b0);
         begin
            repeat (4) @(negedge s_axi_aclk);
            emwr_progfull = 1'b1;
            pf_start      = cyc;
            repeat (12) @(negedge s_axi_aclk);
            emwr_progfull = 1'b0;
         end
      join

      // mesh and register reads mixed
      for (int i = 0; i < n_rd; i++)
      begin
         loc = (rand_bits(2) == 0);
         grp = 2'(rand_bits(2));
         if (loc)
            read_burst({10'h010, 2'b00, grp, 4'h0, 12'(rand_bits(12))}, burst_incr,
                       2'(rand_bits(2) % 3), 1 + int'(rand_bits(2)), 1'b1);
         else
            read_burst({1'b1, 29'(rand_bits(29))}, burst_e'(rand_bits(2) % 3),
                       2'(rand_bits(2) % 3), 1 + int'(rand_bits(3)), 1'b0);
      end

      repeat (10) @(negedge s_axi_aclk);
      if (exp_wr.size() != 0 || exp_mi.size() != 0 || exp_rq.size() != 0 ||
          exp_rd.size() != 0 || exp_b != 0)
         fail_now("expected transfers never showed up");
      else
         $display("Regression passed");
      $finish;
   end

endmodule
